/* Makefile */
TOOL     := verilator
FLAGS    := --timing --assert --timescale 1ns/1ps
TOP      := tb_riscv_ctrl
RTL_TOP  := riscv_ctrl
FILELIST := riscv_ctrl.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_settings.svh"

package ctrl_pkg;

  // pc source, values 1 and 6..7 are not used by this controller
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT      = 0,
    PC_JUMP      = 2,
    PC_BRANCH    = 3,
    PC_EXCEPTION = 4,
    PC_ERET      = 5
  } pc_mux_e;

  // where an id operand is taken from
  typedef enum logic [`CTRL_FW_SEL_W-1:0] {
    SEL_REGFILE = 0,
    SEL_FW_EX   = 1,
    SEL_FW_WB   = 2
  } fw_sel_e;

  // jump kind as seen by the decoder
  typedef enum logic [`CTRL_JUMP_W-1:0] {
    BR_NONE = 0,
    BR_JAL  = 1,
    BR_JALR = 2,
    BR_COND = 3
  } jump_e;

  typedef enum logic [`CTRL_STATE_W-1:0] {
    RESET, BOOT_SET, SLEEP, FIRST_FETCH, DECODE, FLUSH_EX, FLUSH_WB
  } ctrl_state_e;

  // one bit per source operand, set when a destination equals it
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } operand_mask_t;

  // destination matches per pipeline stage
  typedef struct packed {
    operand_mask_t ex;
    operand_mask_t wb;
    operand_mask_t alu;
  } reg_match_t;

  typedef struct packed {
    logic ex;
    logic wb;
    logic alu;
  } rf_we_t;

  typedef struct packed {
    fw_sel_e a;
    fw_sel_e b;
    fw_sel_e c;
  } fw_sel_t;

  // exception save and restore strobes towards the csr block
  typedef struct packed {
    logic save_if;
    logic save_id;
    logic save_branch;
    logic restore_id;
  } exc_save_t;

endpackage

`default_nettype wire

/* common/ctrl_settings.svh */
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

////////////////////////////////////////
// controller field widths
////////////////////////////////////////

// pc source select towards the fetch stage
`define CTRL_PC_MUX_W 3

// operand forwarding mux select
`define CTRL_FW_SEL_W 2

// jump kind code from the decoder
`define CTRL_JUMP_W 2

// seven fsm states fit in three bits
`define CTRL_STATE_W 3

`endif

/* ctrl_fsm/ctrl_fsm.sv */
`default_nettype none

module ctrl_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_enable_i,
  input  logic                instr_valid_i,
  input  logic                id_ready_i,
  input  logic                ex_valid_i,
  input  logic                branch_taken_ex_i,
  input  ctrl_pkg::jump_e     jump_in_dec_i,
  input  logic                mret_insn_i,
  input  logic                pipe_flush_i,
  input  logic                int_req_i,
  input  logic                ext_req_i,
  input  logic                jr_stall_i,
  output logic                ctrl_busy_o,
  output logic                is_decoding_o,
  output logic                instr_req_o,
  output logic                pc_set_o,
  output ctrl_pkg::pc_mux_e   pc_mux_o,
  output logic                halt_if_o,
  output logic                halt_id_o,
  output logic                exc_ack_o,
  output logic                irq_ack_o,
  output ctrl_pkg::exc_save_t exc_save_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;
  // blocks a second redirect for the same instruction in id
  logic jump_done_q;
  logic jump_done_d;
  logic exc_req;
  logic is_jump;

  assign exc_req = int_req_i | ext_req_i;
  // only unconditional jumps are redirected from decode
  assign is_jump = (jump_in_dec_i == ctrl_pkg::BR_JAL) || (jump_in_dec_i == ctrl_pkg::BR_JALR);

  ////////////////////////////////////////
  // next state and output decode
  ////////////////////////////////////////

  always_comb begin
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = ctrl_pkg::PC_BOOT;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_ack_o     = 1'b0;
    irq_ack_o     = 1'b0;
    exc_save_o    = '0;
    jump_done_d   = jump_done_q;
    state_d       = state_q;

    case (state_q)
      // idle after reset until fetching is enabled
      ctrl_pkg::RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::BOOT_SET;
        end
      end

      // load the boot address into the fetch pc
      ctrl_pkg::BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = ctrl_pkg::PC_BOOT;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      // pipeline drained, wake on enable or any request
      ctrl_pkg::SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end
      end

      ctrl_pkg::FIRST_FETCH: begin
        // wait for the first instruction to reach id
        if (id_ready_i) begin
          state_d = ctrl_pkg::DECODE;
        end
        // pending request taken before anything was decoded
        if (exc_req) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = ctrl_pkg::PC_EXCEPTION;
          exc_ack_o          = 1'b1;
          irq_ack_o          = ext_req_i;
          exc_save_o.save_if = 1'b1;
        end
      end

      ctrl_pkg::DECODE: begin
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;
          if (is_jump) begin
            // target known in id, wait out a jr hazard first
            pc_mux_o = ctrl_pkg::PC_JUMP;
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (exc_req) begin
            // keep the id instruction out of ex and save its pc
            pc_set_o           = 1'b1;
            pc_mux_o           = ctrl_pkg::PC_EXCEPTION;
            exc_ack_o          = 1'b1;
            irq_ack_o          = ext_req_i;
            halt_id_o          = 1'b1;
            exc_save_o.save_id = 1'b1;
          end
          if (mret_insn_i) begin
            pc_mux_o              = ctrl_pkg::PC_ERET;
            exc_save_o.restore_id = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          // wfi or mret back to sleep drains ex and wb
          if (pipe_flush_i || (mret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
        end

        // empty id slot, external request saves the if pc
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = ctrl_pkg::PC_EXCEPTION;
          exc_ack_o          = 1'b1;
          irq_ack_o          = 1'b1;
          halt_id_o          = 1'b1;
          exc_save_o.save_if = 1'b1;
        end

        // taken branch in ex squashes the id instruction
        if (branch_taken_ex_i) begin
          pc_set_o = 1'b1;
          pc_mux_o = ctrl_pkg::PC_BRANCH;
          if (ext_req_i) begin
            // handler returns to the branch target
            pc_mux_o               = ctrl_pkg::PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            irq_ack_o              = 1'b1;
            halt_id_o              = 1'b1;
            exc_save_o.save_branch = 1'b1;
          end
        end
      end

      // nop into ex until the last instruction completes
      ctrl_pkg::FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = ctrl_pkg::FLUSH_WB;
        end
      end

      // one more cycle for wb, then resume or sleep
      ctrl_pkg::FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = ctrl_pkg::DECODE;
        end else begin
          state_d = ctrl_pkg::SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // state and jump lockout registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // released once id accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

/* riscv_ctrl.f */
+incdir+common
common/ctrl_pkg.sv
ctrl_fsm/ctrl_fsm.sv
verilog/hazard_unit.sv
verilog/fwd_unit.sv
verilog/riscv_ctrl.sv
test/riscv_ctrl_props.sv
test/tb_riscv_ctrl.sv

/* test/riscv_ctrl_props.sv */
`default_nettype none

module riscv_ctrl_props (
  input logic clk,
  input logic rst_n,
  input logic pc_set_i,
  input logic exc_ack_i,
  input logic irq_ack_i,
  input logic jr_stall_i,
  input logic deassert_we_i
);
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // redirect and acknowledge rules
  ////////////////////////////////////////

  // an exception is always taken through a pc redirect
  exc_ack_redirects: assert property (@(posedge clk) disable iff (!rst_n)
    exc_ack_i |-> pc_set_i) else $error("exc_ack_o high without pc_set_o");

  // irq acknowledge is a subset of the exception acknowledge
  irq_ack_is_exc: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_i |-> exc_ack_i) else $error("irq_ack_o high without exc_ack_o");

  // a stalled jalr must not write the register file
  jr_stall_kills_we: assert property (@(posedge clk) disable iff (!rst_n)
    jr_stall_i |-> deassert_we_i) else $error("jr_stall_o high with deassert_we_o low");

endmodule

bind riscv_ctrl riscv_ctrl_props props_i (
  .clk, .rst_n, .pc_set_i(pc_set_o), .exc_ack_i(exc_ack_o), .irq_ack_i(irq_ack_o),
  .jr_stall_i(jr_stall_o), .deassert_we_i(deassert_we_o)
);

`default_nettype wire

/* test/tb_riscv_ctrl.sv */
`default_nettype none

module tb_riscv_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  // six tests of up to about 200 cycles each plus reset and margin
  localparam int MAX_CYCLES = 2000;

  logic clk;
  logic rst_n;
  logic fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i, branch_taken_ex_i;
  logic illegal_insn_i, mret_insn_i, pipe_flush_i, int_req_i, ext_req_i;
  logic data_req_ex_i, data_misaligned_i, mult_multicycle_i;
  ctrl_pkg::jump_e      jump_in_dec_i;
  ctrl_pkg::jump_e      jump_in_id_i;
  ctrl_pkg::rf_we_t     rf_we_i;
  ctrl_pkg::reg_match_t reg_match_i;
  logic ctrl_busy_o, is_decoding_o, instr_req_o, pc_set_o, halt_if_o, halt_id_o;
  logic exc_ack_o, irq_ack_o, deassert_we_o, load_stall_o, jr_stall_o;
  ctrl_pkg::pc_mux_e    pc_mux_o;
  ctrl_pkg::exc_save_t  exc_save_o;
  ctrl_pkg::fw_sel_t    fw_sel_o;

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;

  riscv_ctrl dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_pc_mux(input string name, input ctrl_pkg::pc_mux_e got,
                              input ctrl_pkg::pc_mux_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_fw_sel(input string name, input ctrl_pkg::fw_sel_t got,
                              input ctrl_pkg::fw_sel_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_exc_save(input string name, input ctrl_pkg::exc_save_t got,
                                input ctrl_pkg::exc_save_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////
  // helpers and reference rules
  ////////////////////////////////////////

  // everything except enable, ready, valid and reset goes quiet
  task automatic quiet_inputs();
    ex_valid_i        = 1'b0;
    branch_taken_ex_i = 1'b0;
    jump_in_dec_i     = ctrl_pkg::BR_NONE;
    jump_in_id_i      = ctrl_pkg::BR_NONE;
    illegal_insn_i    = 1'b0;
    mret_insn_i       = 1'b0;
    pipe_flush_i      = 1'b0;
    int_req_i         = 1'b0;
    ext_req_i         = 1'b0;
    data_req_ex_i     = 1'b0;
    data_misaligned_i = 1'b0;
    mult_multicycle_i = 1'b0;
    rf_we_i           = '0;
    reg_match_i       = '0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, errors - errors_before);
  endtask

  task automatic check_exception_redirect(input logic exp_irq,
                                          input ctrl_pkg::exc_save_t exp_save);
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_mux("pc_mux_o", pc_mux_o, ctrl_pkg::PC_EXCEPTION);
    check_bit("exc_ack_o", exc_ack_o, 1'b1);
    check_bit("irq_ack_o", irq_ack_o, exp_irq);
    check_exc_save("exc_save_o", exc_save_o, exp_save);
  endtask

  // alu result first, then wb result, else the register file
  function automatic ctrl_pkg::fw_sel_e operand_src(input logic wb_hit, input logic alu_hit);
    if (alu_hit) begin
      return ctrl_pkg::SEL_FW_EX;
    end else if (wb_hit) begin
      return ctrl_pkg::SEL_FW_WB;
    end
    return ctrl_pkg::SEL_REGFILE;
  endfunction

  function automatic ctrl_pkg::fw_sel_t fwd_model(input ctrl_pkg::rf_we_t we,
      input ctrl_pkg::reg_match_t rm, input logic mis, input logic mul);
    ctrl_pkg::fw_sel_t sel;
    sel.a = operand_src(we.wb & rm.wb.a, we.alu & rm.alu.a);
    sel.b = operand_src(we.wb & rm.wb.b, we.alu & rm.alu.b);
    sel.c = operand_src(we.wb & rm.wb.c, we.alu & rm.alu.c);
    if (mis) begin
      sel.a = ctrl_pkg::SEL_FW_EX;
      sel.b = ctrl_pkg::SEL_REGFILE;
    end else if (mul) begin
      sel.c = ctrl_pkg::SEL_FW_EX;
    end
    return sel;
  endfunction

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_boot();
    int e0;
    e0 = errors;
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    check_bit("pc_set_o", pc_set_o, 1'b0);
    check_bit("deassert_we_o", deassert_we_o, 1'b1);
    @(negedge clk);
    fetch_enable_i = 1'b1;
    #1;
    check_bit("pc_set_o", pc_set_o, 1'b0);
    @(negedge clk);
    #1;
    // boot address load as a single strobe
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_mux("pc_mux_o", pc_mux_o, ctrl_pkg::PC_BOOT);
    check_bit("instr_req_o", instr_req_o, 1'b1);
    @(negedge clk);
    id_ready_i    = 1'b1;
    instr_valid_i = 1'b1;
    #1;
    check_bit("pc_set_o", pc_set_o, 1'b0);
    @(negedge clk);
    #1;
    check_bit("is_decoding_o", is_decoding_o, 1'b1);
    report_test("reset_boot", e0);
  endtask

  task automatic test_forwarding();
    int e0;
    logic [31:0] r;
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      @(negedge clk);
      r = $urandom();
      rf_we_i     = r[2:0];
      reg_match_i = r[11:3];
      // overrides rarer than plain matches
      data_misaligned_i = (r[14:12] == 3'd0);
      mult_multicycle_i = (r[17:15] == 3'd0);
      #1;
      check_fw_sel("fw_sel_o", fw_sel_o,
                   fwd_model(rf_we_i, reg_match_i, data_misaligned_i, mult_multicycle_i));
    end
    @(negedge clk);
    quiet_inputs();
    report_test("forwarding", e0);
  endtask

  task automatic test_hazards();
    int e0;
    logic [31:0] r;
    logic exp_load;
    logic exp_jr;
    e0 = errors;
    for (int i = 0; i < 150; i++) begin
      @(negedge clk);
      r = $urandom();
      rf_we_i        = r[2:0];
      reg_match_i    = r[11:3];
      data_req_ex_i  = r[12];
      jump_in_dec_i  = ctrl_pkg::jump_e'(r[14:13]);
      illegal_insn_i = r[15];
      // toggles decoding on and off
      instr_valid_i  = r[16];
      // a load stalls on any operand its destination matches
      exp_load = 1'b0;
      if (data_req_ex_i && rf_we_i.ex && reg_match_i.ex != '0) begin
        exp_load = 1'b1;
      end
      // a jalr waits while any later stage still owns its base register
      exp_jr = 1'b0;
      if (jump_in_dec_i == ctrl_pkg::BR_JALR) begin
        if (rf_we_i.ex && reg_match_i.ex.a) begin
          exp_jr = 1'b1;
        end
        if (rf_we_i.wb && reg_match_i.wb.a) begin
          exp_jr = 1'b1;
        end
        if (rf_we_i.alu && reg_match_i.alu.a) begin
          exp_jr = 1'b1;
        end
      end
      #1;
      check_bit("is_decoding_o", is_decoding_o, instr_valid_i);
      check_bit("load_stall_o", load_stall_o, exp_load);
      check_bit("jr_stall_o", jr_stall_o, exp_jr);
      check_bit("deassert_we_o", deassert_we_o,
                ~instr_valid_i | illegal_insn_i | exp_load | exp_jr);
    end
    @(negedge clk);
    quiet_inputs();
    instr_valid_i = 1'b1;
    report_test("hazards", e0);
  endtask

  task automatic test_jumps_branches();
    int e0;
    ctrl_pkg::exc_save_t exp_save;
    e0 = errors;
    @(negedge clk);
    jump_in_dec_i = ctrl_pkg::BR_JAL;
    id_ready_i    = 1'b0;
    #1;
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_mux("pc_mux_o", pc_mux_o, ctrl_pkg::PC_JUMP);
    // same jal held in id gives no second redirect
    repeat (4) begin
      @(negedge clk);
      #1;
      check_bit("pc_set_o", pc_set_o, 1'b0);
    end
    @(negedge clk);
    id_ready_i = 1'b1;
    #1;
    check_bit("pc_set_o", pc_set_o, 1'b0);
    @(negedge clk);
    jump_in_dec_i     = ctrl_pkg::BR_NONE;
    branch_taken_ex_i = 1'b1;
    #1;
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_mux("pc_mux_o", pc_mux_o, ctrl_pkg::PC_BRANCH);
    check_bit("is_decoding_o", is_decoding_o, 1'b0);
    check_bit("exc_ack_o", exc_ack_o, 1'b0);
    @(negedge clk);
    ext_req_i = 1'b1;
    #1;
    exp_save = '0;
    exp_save.save_branch = 1'b1;
    check_exception_redirect(1'b1, exp_save);
    @(negedge clk);
    quiet_inputs();
    report_test("jumps_branches", e0);
  endtask

  task automatic test_decode_interrupts();
    int e0;
    ctrl_pkg::exc_save_t exp_save;
    e0 = errors;
    exp_save = '0;
    exp_save.save_id = 1'b1;
    @(negedge clk);
    int_req_i = 1'b1;
    #1;
    check_exception_redirect(1'b0, exp_save);
    check_bit("halt_id_o", halt_id_o, 1'b1);
    @(negedge clk);
    int_req_i = 1'b0;
    ext_req_i = 1'b1;
    #1;
    check_exception_redirect(1'b1, exp_save);
    check_bit("halt_id_o", halt_id_o, 1'b1);
    @(negedge clk);
    ext_req_i   = 1'b0;
    mret_insn_i = 1'b1;
    #1;
    exp_save = '0;
    exp_save.restore_id = 1'b1;
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_mux("pc_mux_o", pc_mux_o, ctrl_pkg::PC_ERET);
    check_exc_save("exc_save_o", exc_save_o, exp_save);
    @(negedge clk);
    quiet_inputs();
    report_test("decode_interrupts", e0);
  endtask

  task automatic test_flush_sleep();
    int e0;
    ctrl_pkg::exc_save_t exp_save;
    e0 = errors;
    @(negedge clk);
    pipe_flush_i = 1'b1;
    #1;
    check_bit("halt_if_o", halt_if_o, 1'b1);
    check_bit("halt_id_o", halt_id_o, 1'b1);
    @(negedge clk);
    pipe_flush_i   = 1'b0;
    fetch_enable_i = 1'b0;
    #1;
    // still busy while ex drains
    check_bit("halt_if_o", halt_if_o, 1'b1);
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    @(negedge clk);
    ex_valid_i = 1'b1;
    @(negedge clk);
    ex_valid_i = 1'b0;
    #1;
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    @(negedge clk);
    ext_req_i = 1'b1;
    #1;
    // asleep when the request shows up
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    check_bit("halt_if_o", halt_if_o, 1'b1);
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("pc_set_o", pc_set_o, 1'b0);
    @(negedge clk);
    #1;
    exp_save = '0;
    exp_save.save_if = 1'b1;
    check_exception_redirect(1'b1, exp_save);
    @(negedge clk);
    quiet_inputs();
    report_test("flush_sleep", e0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'he93c_3f57));
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    id_ready_i     = 1'b0;
    instr_valid_i  = 1'b0;
    quiet_inputs();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    #1;
    test_reset_boot();
    test_forwarding();
    test_hazards();
    test_jumps_branches();
    test_decode_interrupts();
    test_flush_sleep();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/fwd_unit.sv */
`default_nettype none

module fwd_unit (
  input  logic                 data_misaligned_i,
  input  logic                 mult_multicycle_i,
  input  ctrl_pkg::rf_we_t     rf_we_i,
  input  ctrl_pkg::reg_match_t reg_match_i,
  output ctrl_pkg::fw_sel_t    fw_sel_o
);

  // per operand priority, alu result beats wb result
  function automatic ctrl_pkg::fw_sel_e pick_src(input logic wb_hit, input logic alu_hit);
    ctrl_pkg::fw_sel_e src;
    src = ctrl_pkg::SEL_REGFILE;
    if (wb_hit) begin
      src = ctrl_pkg::SEL_FW_WB;
    end
    if (alu_hit) begin
      src = ctrl_pkg::SEL_FW_EX;
    end
    return src;
  endfunction

  always_comb begin
    fw_sel_o.a = pick_src(rf_we_i.wb & reg_match_i.wb.a, rf_we_i.alu & reg_match_i.alu.a);
    fw_sel_o.b = pick_src(rf_we_i.wb & reg_match_i.wb.b, rf_we_i.alu & reg_match_i.alu.b);
    fw_sel_o.c = pick_src(rf_we_i.wb & reg_match_i.wb.c, rf_we_i.alu & reg_match_i.alu.c);

    if (data_misaligned_i) begin
      // second half of a misaligned access reuses the ex address
      fw_sel_o.a = ctrl_pkg::SEL_FW_EX;
      fw_sel_o.b = ctrl_pkg::SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multicycle multiply keeps its partial result on c
      fw_sel_o.c = ctrl_pkg::SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`default_nettype none

module hazard_unit (
  input  logic                 is_decoding_i,
  input  logic                 illegal_insn_i,
  input  logic                 data_req_ex_i,
  input  ctrl_pkg::jump_e      jump_in_dec_i,
  input  ctrl_pkg::rf_we_t     rf_we_i,
  input  ctrl_pkg::reg_match_t reg_match_i,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output logic                 deassert_we_o
);

  logic a_written;

  ////////////////////////////////////////
  // load-use hazard
  ////////////////////////////////////////

  // load in ex writes a register that id reads
  assign load_stall_o = data_req_ex_i & rf_we_i.ex & (|reg_match_i.ex);

  ////////////////////////////////////////
  // jump-register hazard
  ////////////////////////////////////////

  // jalr base is operand a, any pending writer of it stalls
  assign a_written = (rf_we_i.ex  & reg_match_i.ex.a)
                   | (rf_we_i.wb  & reg_match_i.wb.a)
                   | (rf_we_i.alu & reg_match_i.alu.a);

  assign jr_stall_o = (jump_in_dec_i == ctrl_pkg::BR_JALR) & a_written;

  // no side effects unless a legal instruction really decodes
  assign deassert_we_o = ~is_decoding_i
                       | illegal_insn_i
                       | load_stall_o
                       | jr_stall_o;

endmodule

`default_nettype wire

/* verilog/riscv_ctrl.sv */
`default_nettype none

module riscv_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_e      jump_in_dec_i,
  input  ctrl_pkg::jump_e      jump_in_id_i,
  input  logic                 illegal_insn_i,
  input  logic                 mret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 int_req_i,
  input  logic                 ext_req_i,
  input  logic                 data_req_ex_i,
  input  logic                 data_misaligned_i,
  input  logic                 mult_multicycle_i,
  input  ctrl_pkg::rf_we_t     rf_we_i,
  input  ctrl_pkg::reg_match_t reg_match_i,
  output logic                 ctrl_busy_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_e    pc_mux_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 exc_ack_o,
  output logic                 irq_ack_o,
  output ctrl_pkg::exc_save_t  exc_save_o,
  output logic                 deassert_we_o,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output ctrl_pkg::fw_sel_t    fw_sel_o
);

  ////////////////////////////////////////
  // control fsm and pc redirect
  ////////////////////////////////////////

  // jr_stall comes from the hazard unit, is_decoding goes back to it
  ctrl_fsm fsm_i (
    .clk, .rst_n, .fetch_enable_i, .instr_valid_i, .id_ready_i, .ex_valid_i,
    .branch_taken_ex_i, .jump_in_dec_i, .mret_insn_i, .pipe_flush_i,
    .int_req_i, .ext_req_i, .jr_stall_i(jr_stall_o),
    .ctrl_busy_o, .is_decoding_o, .instr_req_o, .pc_set_o, .pc_mux_o,
    .halt_if_o, .halt_id_o, .exc_ack_o, .irq_ack_o, .exc_save_o
  );

  // stalls and write enable kill
  hazard_unit hazard_i (
    .is_decoding_i(is_decoding_o), .illegal_insn_i, .data_req_ex_i,
    .jump_in_dec_i, .rf_we_i, .reg_match_i,
    .load_stall_o, .jr_stall_o, .deassert_we_o
  );

  // operand bypass selects for id
  fwd_unit fwd_i (
    .data_misaligned_i, .mult_multicycle_i, .rf_we_i, .reg_match_i, .fw_sel_o
  );

endmodule

`default_nettype wire
